// File: common/c4_pkg.sv
package c4_pkg;

	// board geometry
	// row 0 is the bottom row, column 0 the leftmost
	localparam int ROWS    = 6;
	localparam int COLS    = 7;
	localparam int WIN_LEN = 4;
	localparam int CELLS   = ROWS * COLS;

	// index widths
	localparam int ROW_W = 3;
	localparam int COL_W = 3;

	// player to move
	typedef enum logic {
		P1 = 1'b0,
		P2 = 1'b1
	} player_e;

	// game outcome shown on the result output
	typedef enum logic [1:0] {
		NONE   = 2'd0,
		P1_WON = 2'd1,
		P2_WON = 2'd2,
		TIE    = 2'd3
	} result_e;

	// controller states
	typedef enum logic [2:0] {
		CLEAR = 3'd0,
		PLAY  = 3'd1,
		PLACE = 3'd2,
		CHECK = 3'd3,
		OVER  = 3'd4
	} game_state_e;

	// one bit per cell, indexed [row][col]
	typedef logic [ROWS-1:0][COLS-1:0] plane_t;

	// a placed chip
	typedef struct packed {
		player_e          player;
		logic [ROW_W-1:0] row;
		logic [COL_W-1:0] col;
	} move_t;

endpackage

// File: game_ctrl/game_ctrl.sv
module game_ctrl (
	input  logic              clk,
	input  logic              reset,
	input  logic              restart,
	input  logic              move_valid,
	input  logic              clear_done,
	input  logic              four_found,
	input  logic              board_full,
	output logic              drop_en,
	output logic              clear_en,
	output c4_pkg::player_e   turn,
	output c4_pkg::result_e   result,
	output logic              ready
);

	c4_pkg::game_state_e state;
	c4_pkg::game_state_e cur_state;
	c4_pkg::game_state_e next_state;

	// a move report ends PLAY in the same cycle
	// so the board write happens while the FSM is in PLACE
	always_comb
	begin
		cur_state = state;
		if (state == c4_pkg::PLAY && move_valid)
			cur_state = c4_pkg::PLACE;
	end

	always_comb
	begin
		next_state = cur_state;
		case (cur_state)
			c4_pkg::CLEAR:
				if (clear_done)
					next_state = c4_pkg::PLAY;
			c4_pkg::PLAY:
				next_state = c4_pkg::PLAY;
			c4_pkg::PLACE:
				next_state = c4_pkg::CHECK;
			c4_pkg::CHECK:
				if (four_found || board_full)
					next_state = c4_pkg::OVER;
				else
					next_state = c4_pkg::PLAY;
			c4_pkg::OVER:
				next_state = c4_pkg::OVER;
			default:
				next_state = c4_pkg::CLEAR;
		endcase
		// restart beats everything except a sweep already running
		if (restart && cur_state != c4_pkg::CLEAR)
			next_state = c4_pkg::CLEAR;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state  <= c4_pkg::CLEAR;
			turn   <= c4_pkg::P1;
			result <= c4_pkg::NONE;
		end
		else
		begin
			state <= next_state;
			if (next_state == c4_pkg::CLEAR)
			begin
				// fresh board, P1 opens
				turn   <= c4_pkg::P1;
				result <= c4_pkg::NONE;
			end
			else if (cur_state == c4_pkg::CHECK)
			begin
				// a win on the last cell still counts as a win
				if (four_found)
					result <= (turn == c4_pkg::P1) ? c4_pkg::P1_WON : c4_pkg::P2_WON;
				else if (board_full)
					result <= c4_pkg::TIE;
				else
					turn <= (turn == c4_pkg::P1) ? c4_pkg::P2 : c4_pkg::P1;
			end
		end
	end

	assign ready    = (cur_state == c4_pkg::PLAY);
	assign drop_en  = ready && !restart;
	assign clear_en = (state == c4_pkg::CLEAR);

endmodule

// File: game_ctrl/clear_sweep.sv
module clear_sweep (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clear_en,
	output logic [c4_pkg::ROW_W-1:0]  clear_row,
	output logic                      clear_done
);

	logic [c4_pkg::ROW_W-1:0] row_q;

	// one row per cycle, bottom to top
	always_ff @(posedge clk)
	begin
		if (!reset || !clear_en)
			row_q <= '0;
		else if (row_q == c4_pkg::ROWS - 1)
			row_q <= '0;
		else
			row_q <= row_q + 1'b1;
	end

	assign clear_row = row_q;

	// high while the top row is being cleared
	assign clear_done = clear_en && (row_q == c4_pkg::ROWS - 1);

endmodule

// File: board/column_fill.sv
module column_fill (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [c4_pkg::COLS-1:0]   column,
	input  logic                      drop,
	input  logic                      drop_en,
	input  c4_pkg::player_e           turn,
	input  logic                      clear_en,
	output logic                      move_valid,
	output c4_pkg::move_t             move,
	output logic                      board_full
);

	// chips held per column, also the next free row
	logic [c4_pkg::COLS-1:0][c4_pkg::ROW_W-1:0] heights;
	logic [c4_pkg::COL_W-1:0]                   col_idx;
	logic                                       one_hot;
	logic                                       accept;
	logic [$clog2(c4_pkg::CELLS+1)-1:0]         chip_count;

	always_comb
	begin
		col_idx = '0;
		for (int k = 0; k < c4_pkg::COLS; k++)
			if (column[k])
				col_idx = k[c4_pkg::COL_W-1:0];
	end

	assign one_hot = (column != '0) && ((column & (column - 1'b1)) == '0);
	assign accept  = drop && drop_en && one_hot && (heights[col_idx] < c4_pkg::ROWS);

	always_ff @(posedge clk)
	begin
		if (!reset || clear_en)
			heights <= '0;
		else if (accept)
			heights[col_idx] <= heights[col_idx] + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			move_valid <= 1'b0;
		else
			move_valid <= accept;
	end

	// chip lands on the current height of its column
	always_ff @(posedge clk)
	begin
		if (!reset)
			move <= '0;
		else if (accept)
		begin
			move.player <= turn;
			move.row    <= heights[col_idx];
			move.col    <= col_idx;
		end
	end

	always_comb
	begin
		chip_count = '0;
		for (int k = 0; k < c4_pkg::COLS; k++)
			chip_count = chip_count + heights[k];
	end

	assign board_full = (chip_count == c4_pkg::CELLS);

endmodule

// File: board/board_store.sv
module board_store (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      move_valid,
	input  c4_pkg::move_t             move,
	input  logic                      clear_en,
	input  logic [c4_pkg::ROW_W-1:0]  clear_row,
	output c4_pkg::plane_t            p1_plane,
	output c4_pkg::plane_t            p2_plane
);

	logic move_p1;
	logic move_p2;

	assign move_p1 = move_valid && (move.player == c4_pkg::P1);
	assign move_p2 = move_valid && (move.player == c4_pkg::P2);

	always_ff @(posedge clk)
	begin
		if (!reset)
			p1_plane <= '0;
		else
		begin
			if (move_p1)
				p1_plane[move.row][move.col] <= 1'b1;
			// later assignment lets the sweep win on the same row
			if (clear_en)
				p1_plane[clear_row] <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			p2_plane <= '0;
		else
		begin
			if (move_p2)
				p2_plane[move.row][move.col] <= 1'b1;
			if (clear_en)
				p2_plane[clear_row] <= '0;
		end
	end

endmodule

// File: board/win_detect.sv
module win_detect (
	input  c4_pkg::player_e  turn,
	input  c4_pkg::plane_t   p1_plane,
	input  c4_pkg::plane_t   p2_plane,
	output logic             four_found
);

	c4_pkg::plane_t plane;
	logic           found;

	// WIN_LEN cells from (r, c) stepping by (dr, dc)
	function automatic logic line_at(c4_pkg::plane_t pl, int r, int c, int dr, int dc);
		logic hit;
		hit = 1'b1;
		for (int k = 0; k < c4_pkg::WIN_LEN; k++)
			hit = hit & pl[r + k * dr][c + k * dc];
		return hit;
	endfunction

	// only the mover can have just completed a line
	assign plane = (turn == c4_pkg::P1) ? p1_plane : p2_plane;

	always_comb
	begin
		found = 1'b0;
		// horizontal
		for (int r = 0; r < c4_pkg::ROWS; r++)
			for (int c = 0; c <= c4_pkg::COLS - c4_pkg::WIN_LEN; c++)
				found = found | line_at(plane, r, c, 0, 1);
		// vertical
		for (int r = 0; r <= c4_pkg::ROWS - c4_pkg::WIN_LEN; r++)
			for (int c = 0; c < c4_pkg::COLS; c++)
				found = found | line_at(plane, r, c, 1, 0);
		// rising diagonal, up and to the right
		for (int r = 0; r <= c4_pkg::ROWS - c4_pkg::WIN_LEN; r++)
			for (int c = 0; c <= c4_pkg::COLS - c4_pkg::WIN_LEN; c++)
				found = found | line_at(plane, r, c, 1, 1);
		// falling diagonal, starts high and steps down to the right
		for (int r = c4_pkg::WIN_LEN - 1; r < c4_pkg::ROWS; r++)
			for (int c = 0; c <= c4_pkg::COLS - c4_pkg::WIN_LEN; c++)
				found = found | line_at(plane, r, c, -1, 1);
	end

	assign four_found = found;

endmodule

// File: verilog/c4_top.sv
module c4_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [c4_pkg::COLS-1:0]   column,
	input  logic                      drop,
	input  logic                      restart,
	output logic                      move_valid,
	output c4_pkg::move_t             move,
	output c4_pkg::player_e           turn,
	output c4_pkg::result_e           result,
	output logic                      ready
);

	logic                      drop_en;
	logic                      clear_en;
	logic [c4_pkg::ROW_W-1:0]  clear_row;
	logic                      clear_done;
	logic                      board_full;
	logic                      four_found;
	c4_pkg::plane_t            p1_plane;
	c4_pkg::plane_t            p2_plane;

	// turn order, result and restart
	game_ctrl u_game_ctrl (
		.clk        (clk),
		.reset      (reset),
		.restart    (restart),
		.move_valid (move_valid),
		.clear_done (clear_done),
		.four_found (four_found),
		.board_full (board_full),
		.drop_en    (drop_en),
		.clear_en   (clear_en),
		.turn       (turn),
		.result     (result),
		.ready      (ready)
	);

	clear_sweep u_clear_sweep (
		.clk        (clk),
		.reset      (reset),
		.clear_en   (clear_en),
		.clear_row  (clear_row),
		.clear_done (clear_done)
	);

	// column heights and move report
	column_fill u_column_fill (
		.clk        (clk),
		.reset      (reset),
		.column     (column),
		.drop       (drop),
		.drop_en    (drop_en),
		.turn       (turn),
		.clear_en   (clear_en),
		.move_valid (move_valid),
		.move       (move),
		.board_full (board_full)
	);

	board_store u_board_store (
		.clk        (clk),
		.reset      (reset),
		.move_valid (move_valid),
		.move       (move),
		.clear_en   (clear_en),
		.clear_row  (clear_row),
		.p1_plane   (p1_plane),
		.p2_plane   (p2_plane)
	);

	win_detect u_win_detect (
		.turn       (turn),
		.p1_plane   (p1_plane),
		.p2_plane   (p2_plane),
		.four_found (four_found)
	);

endmodule

// File: sim/clk_gen.sv
module clk_gen (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// held low over the first four rising edges
	initial
	begin
		reset = 1'b0;
		repeat (4)
			@(posedge clk);
		#1;
		reset = 1'b1;
	end

endmodule

// File: sim/c4_chk.sv
module c4_chk (
	input  logic              clk,
	input  logic              reset,
	input  logic              restart,
	input  logic              move_valid,
	input  logic              ready,
	input  c4_pkg::result_e   result
);

	// a move report lasts one cycle
	assert property (@(posedge clk) disable iff (!reset)
		move_valid |=> !move_valid)
	else
		$error("move_valid high in two consecutive cycles");

	// the FSM leaves PLAY on the cycle of the report
	assert property (@(posedge clk) disable iff (!reset)
		!(ready && move_valid))
	else
		$error("ready and move_valid high together");

	// a finished game stays finished until restart
	assert property (@(posedge clk) disable iff (!reset)
		(result != c4_pkg::NONE && !restart) |=> $stable(result))
	else
		$error("result changed without a restart");

	assert property (@(posedge clk) disable iff (!reset)
		(result != c4_pkg::NONE) |-> !ready)
	else
		$error("ready high while a result is shown");

endmodule

// File: sim/tb_top.sv
module tb_top;

	localparam int GAMES      = 20;
	// 40 game slots of 60 cycles, plus reset and slack
	localparam int MAX_CYCLES = 40 * 60 + 200;

	logic                    clk;
	logic                    reset;
	logic [c4_pkg::COLS-1:0] column;
	logic                    drop;
	logic                    restart;
	logic                    move_valid;
	c4_pkg::move_t           move;
	c4_pkg::player_e         turn;
	c4_pkg::result_e         result;
	logic                    ready;

	// model board, 0 empty, 1 for P1, 2 for P2
	int              board [c4_pkg::ROWS][c4_pkg::COLS];
	int              height [c4_pkg::COLS];
	c4_pkg::player_e m_turn;
	c4_pkg::result_e m_result;
	int              seed;
	int              cycle_count = 0;

	// column order of a drawn game, P1 moves on even indices
	int tie_cols [c4_pkg::CELLS] = '{
		0, 1, 1, 0, 1, 0, 0, 1, 0, 1, 1, 0,
		2, 3, 3, 2, 3, 2, 2, 3, 2, 3, 3, 2,
		6, 6, 4, 6, 6, 5, 5, 4, 5, 4, 4, 5,
		4, 5, 5, 4, 6, 6
	};

	clk_gen u_clk_gen (
		.clk   (clk),
		.reset (reset)
	);

	c4_top dut0 (
		.clk        (clk),
		.reset      (reset),
		.column     (column),
		.drop       (drop),
		.restart    (restart),
		.move_valid (move_valid),
		.move       (move),
		.turn       (turn),
		.result     (result),
		.ready      (ready)
	);

	bind c4_top c4_chk chk0 (
		.clk        (clk),
		.reset      (reset),
		.restart    (restart),
		.move_valid (move_valid),
		.ready      (ready),
		.result     (result)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp)
		else
			abort_run($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, exp, got));
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
			abort_run("timeout: the run went past its cycle limit");
	end

	function automatic void clear_model();
		for (int r = 0; r < c4_pkg::ROWS; r++)
			for (int c = 0; c < c4_pkg::COLS; c++)
				board[r][c] = 0;
		for (int c = 0; c < c4_pkg::COLS; c++)
			height[c] = 0;
		m_turn   = c4_pkg::P1;
		m_result = c4_pkg::NONE;
	endfunction

	// walk every cell in each of the four line directions
	function automatic bit has_four(int pl);
		int dr [4] = '{0, 1, 1, 1};
		int dc [4] = '{1, 0, 1, -1};
		int n;
		int rr;
		int cc;
		for (int r = 0; r < c4_pkg::ROWS; r++)
			for (int c = 0; c < c4_pkg::COLS; c++)
				for (int d = 0; d < 4; d++)
				begin
					n = 0;
					for (int k = 0; k < c4_pkg::WIN_LEN; k++)
					begin
						rr = r + k * dr[d];
						cc = c + k * dc[d];
						if (rr >= 0 && rr < c4_pkg::ROWS && cc >= 0 && cc < c4_pkg::COLS)
							if (board[rr][cc] == pl)
								n++;
					end
					if (n == c4_pkg::WIN_LEN)
						return 1'b1;
				end
		return 1'b0;
	endfunction

	// counts edges until ready, driving ignored drops meanwhile
	task automatic wait_ready(input int exp_edges);
		int edges;
		edges = 0;
		do
		begin
			@(posedge clk);
			#1;
			restart = 1'b0;
			edges++;
			check_value("move_valid", 0, move_valid);
			drop   = !ready;
			column = $random(seed);
			assert (edges <= 20)
			else
				abort_run("ready never came back after the board clear");
		end
		while (ready !== 1'b1);
		check_value("ready_latency", exp_edges, edges);
		check_value("turn", c4_pkg::P1, turn);
		check_value("result", c4_pkg::NONE, result);
	endtask

	task automatic drop_chip(input logic [c4_pkg::COLS-1:0] col);
		int  idx;
		int  ones;
		int  filled;
		bit  accept;
		ones = 0;
		idx  = 0;
		for (int k = 0; k < c4_pkg::COLS; k++)
			if (col[k])
			begin
				ones++;
				idx = k;
			end
		accept = (ones == 1) && (height[idx] < c4_pkg::ROWS);
		check_value("ready", 1, ready);
		column = col;
		drop   = 1'b1;
		@(posedge clk);
		#1;
		check_value("move_valid", accept, move_valid);
		if (!accept)
			drop = 1'b0;
		else
		begin
			check_value("move.player", m_turn, move.player);
			check_value("move.row", height[idx], move.row);
			check_value("move.col", idx, move.col);
			board[height[idx]][idx] = (m_turn == c4_pkg::P1) ? 1 : 2;
			height[idx]++;
			// drop stays high through PLACE and CHECK
			column = $random(seed);
			repeat (2)
			begin
				@(posedge clk);
				#1;
				check_value("move_valid", 0, move_valid);
			end
			drop   = 1'b0;
			filled = 0;
			for (int c = 0; c < c4_pkg::COLS; c++)
				filled += height[c];
			if (has_four((m_turn == c4_pkg::P1) ? 1 : 2))
				m_result = (m_turn == c4_pkg::P1) ? c4_pkg::P1_WON : c4_pkg::P2_WON;
			else if (filled == c4_pkg::CELLS)
				m_result = c4_pkg::TIE;
			else
				m_turn = (m_turn == c4_pkg::P1) ? c4_pkg::P2 : c4_pkg::P1;
			check_value("result", m_result, result);
			check_value("turn", m_turn, turn);
			check_value("ready", m_result == c4_pkg::NONE, ready);
		end
	endtask

	task automatic restart_game();
		restart = 1'b1;
		clear_model();
		wait_ready(c4_pkg::ROWS + 1);
	endtask

	task automatic play_random_game();
		logic [c4_pkg::COLS-1:0] col;
		while (m_result == c4_pkg::NONE)
		begin
			col = '0;
			if (($random(seed) & 7) == 0)
				col = $random(seed);
			else
				col[$unsigned($random(seed)) % c4_pkg::COLS] = 1'b1;
			drop_chip(col);
		end
		// a finished board takes no more chips
		column = '0;
		column[$unsigned($random(seed)) % c4_pkg::COLS] = 1'b1;
		drop = 1'b1;
		@(posedge clk);
		#1;
		check_value("move_valid", 0, move_valid);
		drop = 1'b0;
		restart_game();
	endtask

	task automatic play_tie_game();
		int c;
		// dry run of the sequence on the model board
		for (int i = 0; i < c4_pkg::CELLS; i++)
		begin
			c = tie_cols[i];
			board[height[c]][c] = (i % 2 == 0) ? 1 : 2;
			height[c]++;
		end
		assert (!has_four(1) && !has_four(2))
		else
			abort_run("the drawn game sequence contains four in a row");
		clear_model();
		for (int i = 0; i < c4_pkg::CELLS; i++)
			drop_chip(7'b1 << tie_cols[i]);
		check_value("result", c4_pkg::TIE, result);
		restart_game();
	endtask

	task automatic restart_mid_game();
		drop_chip(7'b0001000);
		drop_chip(7'b0001000);
		drop_chip(7'b0000100);
		drop_chip(7'b0001000);
		drop_chip(7'b0010000);
		// restart and a legal drop in the same cycle
		column = 7'b0001000;
		drop   = 1'b1;
		restart_game();
		drop_chip(7'b0001000);
		check_value("move.row", 0, move.row);
	endtask

	initial
	begin
		seed    = 65055;
		column  = '0;
		drop    = 1'b0;
		restart = 1'b0;
		clear_model();
		wait (reset === 1'b1);
		// the sweep already runs during reset
		wait_ready(c4_pkg::ROWS);
		restart_mid_game();
		restart_game();
		play_tie_game();
		for (int g = 0; g < GAMES; g++)
			play_random_game();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: flist.f
common/c4_pkg.sv
game_ctrl/game_ctrl.sv
game_ctrl/clear_sweep.sv
board/column_fill.sv
board/board_store.sv
board/win_detect.sv
verilog/c4_top.sv
sim/clk_gen.sv
sim/c4_chk.sv
sim/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the Connect Four testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f flist.f --Mdir obj_dir -o Vtb_top
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
